//--- tcb_pkg.sv
`default_nettype none

package tcb_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////

  // byte address width
  localparam int unsigned ABW = 32;
  // data word width
  localparam int unsigned DBW = 32;
  // byte lanes per word
  localparam int unsigned BEW = DBW / 8;

  // address, data and byte enable vectors
  typedef logic [ABW-1:0] adr_t;
  typedef logic [DBW-1:0] dat_t;
  typedef logic [BEW-1:0] ben_t;

  //////////////////////////////
  // AXI response codes
  //////////////////////////////

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  // range errors are reported as slave errors
  localparam resp_t RESP_SLVERR = 2'd2;

  // last grant of the read/write alternation
  typedef enum logic {
    ARB_RD,
    ARB_WR
  } arb_t;

endpackage

`default_nettype wire

//--- axil_tcb_req.sv
`timescale 1ns/1ps
`default_nettype none

module axil_tcb_req (
  input  wire                tcb,
  input  wire                arst_n,
  // AXI4-Lite write address
  input  wire                awvalid,
  output logic               awready,
  input  wire tcb_pkg::adr_t awaddr,
  // AXI4-Lite write data
  input  wire                wvalid,
  output logic               wready,
  input  wire tcb_pkg::dat_t wdata,
  input  wire tcb_pkg::ben_t wstrb,
  // AXI4-Lite read address
  input  wire                arvalid,
  output logic               arready,
  input  wire tcb_pkg::adr_t araddr,
  // tightly coupled bus request
  output logic               tcb_trn,
  output logic               tcb_wen,
  output tcb_pkg::adr_t      tcb_adr,
  output tcb_pkg::ben_t      tcb_ben,
  output tcb_pkg::dat_t      tcb_wdt,
  input  wire                tcb_rdy
);

  // pending write halves and pending read
  logic          aw_pend;
  logic          w_pend;
  logic          ar_pend;
  tcb_pkg::adr_t aw_adr;
  tcb_pkg::adr_t ar_adr;
  tcb_pkg::dat_t w_dat;
  tcb_pkg::ben_t w_stb;
  // grant state
  tcb_pkg::arb_t arb_last;
  logic          wr_pend;
  logic          rd_sel;
  logic          req_ld;
  logic          idle;

  //////////////////////////////
  // AXI capture
  //////////////////////////////

  // request register empty and credit available
  assign idle    = ~tcb_trn & tcb_rdy;
  assign awready = ~aw_pend & idle;
  assign wready  = ~w_pend  & idle;
  assign arready = ~ar_pend & idle;

  // pending flags, a handshake sets and a grant clears
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      ar_pend <= 1'b0;
    end else begin
      if (awvalid & awready) aw_pend <= 1'b1;
      else if (req_ld & ~rd_sel) aw_pend <= 1'b0;
      if (wvalid & wready) w_pend <= 1'b1;
      else if (req_ld & ~rd_sel) w_pend <= 1'b0;
      if (arvalid & arready) ar_pend <= 1'b1;
      else if (req_ld & rd_sel) ar_pend <= 1'b0;
    end
  end

  // payload only
  always_ff @(posedge tcb) begin
    if (awvalid & awready) aw_adr <= awaddr;
    if (arvalid & arready) ar_adr <= araddr;
    if (wvalid & wready) begin
      w_dat <= wdata;
      w_stb <= wstrb;
    end
  end

  //////////////////////////////
  // grant and request register
  //////////////////////////////

  // a write is ready once both halves are in
  assign wr_pend = aw_pend & w_pend;
  // read wins unless a write is waiting and read went last
  assign rd_sel  = ar_pend & (~wr_pend | (arb_last == tcb_pkg::ARB_WR));
  assign req_ld  = (ar_pend | wr_pend) & idle;

  // reset to write so the first tie goes to read
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      arb_last <= tcb_pkg::ARB_WR;
      tcb_trn  <= 1'b0;
    end else begin
      if (req_ld) arb_last <= rd_sel ? tcb_pkg::ARB_RD : tcb_pkg::ARB_WR;
      // single cycle pulse
      tcb_trn <= req_ld;
    end
  end

  // reads enable every lane
  always_ff @(posedge tcb) begin
    if (req_ld) begin
      tcb_wen <= ~rd_sel;
      tcb_adr <= rd_sel ? ar_adr : aw_adr;
      tcb_ben <= rd_sel ? '1 : w_stb;
      tcb_wdt <= w_dat;
    end
  end

  // credit is held through the issue cycle
  a_trn_rdy: assert property (@(posedge tcb) disable iff (!arst_n) tcb_trn |-> tcb_rdy)
    else $error("tcb_trn issued without credit");

  // AXI source must hold the address
  a_aw_stable: assert property (@(posedge tcb) disable iff (!arst_n)
    awvalid && !awready |=> $stable(awaddr))
    else $error("awaddr changed while awvalid waits");

endmodule

`default_nettype wire

//--- tcb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_mem #(
  parameter int unsigned SZ  = 1024,
  parameter int unsigned DLY = 2
)(
  input  wire                tcb,
  input  wire                arst_n,
  // request
  input  wire                tcb_trn,
  input  wire                tcb_wen,
  input  wire tcb_pkg::adr_t tcb_adr,
  input  wire tcb_pkg::ben_t tcb_ben,
  input  wire tcb_pkg::dat_t tcb_wdt,
  // delayed response
  output logic               tcb_vld_d,
  output logic               tcb_wen_d,
  output logic               tcb_err_d,
  output tcb_pkg::dat_t      tcb_rdt
);

  // memory address bits and lane bits
  localparam int unsigned AW  = $clog2(SZ);
  localparam int unsigned LBW = $clog2(tcb_pkg::BEW);

  logic [7:0]     mem [0:SZ-1];
  logic           adr_err;
  // stage registers, index 0 is the first register
  logic [DLY-1:0] vld_p;
  logic [DLY-1:0] wen_p;
  logic [DLY-1:0] err_p;
  tcb_pkg::dat_t  rdt_p [0:DLY-1];
  // stage inputs, index 0 is the request itself, DLY the output
  logic [DLY:0]   vld_x;
  logic [DLY:0]   wen_x;
  logic [DLY:0]   err_x;
  tcb_pkg::dat_t  rdt_x [0:DLY];

  // SZ is a power of two, any upper bit set means out of range
  assign adr_err = |tcb_adr[tcb_pkg::ABW-1:AW];

  //////////////////////////////
  // byte array access
  //////////////////////////////

  // aligned access, lane b is byte b of the selected word
  always_ff @(posedge tcb) begin
    if (tcb_trn & tcb_wen & ~adr_err) begin
      for (int b = 0; b < tcb_pkg::BEW; b++) begin
        if (tcb_ben[b]) begin
          mem[{tcb_adr[AW-1:LBW], LBW'(b)}] <= tcb_wdt[8*b +: 8];
        end
      end
    end
  end

  // read word, disabled lanes and errors give zero
  always_comb begin
    for (int b = 0; b < tcb_pkg::BEW; b++) begin
      rdt_x[0][8*b +: 8] = (tcb_ben[b] & ~adr_err) ? mem[{tcb_adr[AW-1:LBW], LBW'(b)}] : 8'h00;
    end
    for (int d = 1; d <= DLY; d++) begin
      rdt_x[d] = rdt_p[d-1];
    end
  end

  //////////////////////////////
  // delay pipeline
  //////////////////////////////

  assign vld_x = {vld_p, tcb_trn};
  assign wen_x = {wen_p, tcb_wen};
  assign err_x = {err_p, adr_err};

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) vld_p <= '0;
    else vld_p <= vld_x[DLY-1:0];
  end

  // stages load only when their input is valid
  always_ff @(posedge tcb) begin
    for (int d = 0; d < DLY; d++) begin
      if (vld_x[d]) begin
        wen_p[d] <= wen_x[d];
        err_p[d] <= err_x[d];
        rdt_p[d] <= rdt_x[d];
      end
    end
  end

  assign tcb_vld_d = vld_x[DLY];
  assign tcb_wen_d = wen_x[DLY];
  assign tcb_err_d = err_x[DLY];
  assign tcb_rdt   = rdt_x[DLY];

  a_adr_known: assert property (@(posedge tcb) disable iff (!arst_n)
    tcb_trn |-> !$isunknown(tcb_adr))
    else $error("unknown address on request");

  // AXI4-Lite writes are word aligned
  a_wr_align: assert property (@(posedge tcb) disable iff (!arst_n)
    tcb_trn && tcb_wen |-> tcb_adr[LBW-1:0] == '0)
    else $error("unaligned write address");

endmodule

`default_nettype wire

//--- tcb_axil_rsp.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_axil_rsp #(
  parameter int unsigned DLY = 2
)(
  input  wire                tcb,
  input  wire                arst_n,
  // request issue and delayed response
  input  wire                tcb_trn,
  input  wire                tcb_vld_d,
  input  wire                tcb_wen_d,
  input  wire                tcb_err_d,
  input  wire tcb_pkg::dat_t tcb_rdt,
  output logic               tcb_rdy,
  // AXI4-Lite write response
  output logic               bvalid,
  input  wire                bready,
  output tcb_pkg::resp_t     bresp,
  // AXI4-Lite read data
  output logic               rvalid,
  input  wire                rready,
  output tcb_pkg::dat_t      rdata,
  output tcb_pkg::resp_t     rresp
);

  // pipeline depth plus two spare entries
  localparam int unsigned DEPTH = DLY + 2;
  localparam int unsigned PW    = $clog2(DEPTH);
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  logic          wen_q [0:DEPTH-1];
  logic          err_q [0:DEPTH-1];
  tcb_pkg::dat_t rdt_q [0:DEPTH-1];
  logic [PW-1:0] wpt;
  logic [PW-1:0] rpt;
  // queued entries
  logic [CW-1:0] cnt;
  // in flight plus queued
  logic [CW-1:0] crd;
  logic          head;
  logic          pop;

  // depth need not be a power of two
  function automatic logic [PW-1:0] ptr_nxt(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH-1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // response queue
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (tcb_vld_d) begin
      wen_q[wpt] <= tcb_wen_d;
      err_q[wpt] <= tcb_err_d;
      rdt_q[wpt] <= tcb_rdt;
    end
  end

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      wpt <= '0;
      rpt <= '0;
      cnt <= '0;
      crd <= '0;
    end else begin
      if (tcb_vld_d) wpt <= ptr_nxt(wpt);
      if (pop) rpt <= ptr_nxt(rpt);
      cnt <= cnt + CW'(tcb_vld_d) - CW'(pop);
      // credit taken at issue, returned at handshake
      crd <= crd + CW'(tcb_trn) - CW'(pop);
    end
  end

  assign tcb_rdy = crd < CW'(DEPTH);

  //////////////////////////////
  // B/R steering
  //////////////////////////////

  assign head   = cnt != '0;
  assign bvalid = head &  wen_q[rpt];
  assign rvalid = head & ~wen_q[rpt];
  assign bresp  = err_q[rpt] ? tcb_pkg::RESP_SLVERR : tcb_pkg::RESP_OKAY;
  assign rresp  = err_q[rpt] ? tcb_pkg::RESP_SLVERR : tcb_pkg::RESP_OKAY;
  assign rdata  = rdt_q[rpt];
  // head leaves on its own channel handshake
  assign pop    = (bvalid & bready) | (rvalid & rready);

  a_no_ovf: assert property (@(posedge tcb) disable iff (!arst_n)
    tcb_vld_d |-> cnt < CW'(DEPTH))
    else $error("response queue overflow");

  a_rdata_hold: assert property (@(posedge tcb) disable iff (!arst_n)
    rvalid && !rready |=> $stable(rdata))
    else $error("rdata changed while rvalid waits");

endmodule

`default_nettype wire

//--- axil_tcb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module axil_tcb_mem #(
  // memory size in bytes, power of two
  parameter int unsigned SZ  = 1024,
  // read delay in cycles
  parameter int unsigned DLY = 2
)(
  input  wire                tcb,
  input  wire                arst_n,
  // write address channel
  input  wire                awvalid,
  output wire                awready,
  input  wire tcb_pkg::adr_t awaddr,
  // write data channel
  input  wire                wvalid,
  output wire                wready,
  input  wire tcb_pkg::dat_t wdata,
  input  wire tcb_pkg::ben_t wstrb,
  // write response channel
  output wire                bvalid,
  input  wire                bready,
  output tcb_pkg::resp_t     bresp,
  // read address channel
  input  wire                arvalid,
  output wire                arready,
  input  wire tcb_pkg::adr_t araddr,
  // read data channel
  output wire                rvalid,
  input  wire                rready,
  output tcb_pkg::dat_t      rdata,
  output tcb_pkg::resp_t     rresp
);

  //////////////////////////////
  // internal bus
  //////////////////////////////

  // request
  logic          tcb_trn;
  logic          tcb_wen;
  tcb_pkg::adr_t tcb_adr;
  tcb_pkg::ben_t tcb_ben;
  tcb_pkg::dat_t tcb_wdt;
  // credit back to the request side
  logic          tcb_rdy;
  // response, DLY cycles after the request
  logic          tcb_vld_d;
  logic          tcb_wen_d;
  logic          tcb_err_d;
  tcb_pkg::dat_t tcb_rdt;

  axil_tcb_req u_req (
    .tcb, .arst_n,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata, .wstrb,
    .arvalid, .arready, .araddr,
    .tcb_trn, .tcb_wen, .tcb_adr, .tcb_ben, .tcb_wdt,
    .tcb_rdy
  );

  tcb_mem #(.SZ(SZ), .DLY(DLY)) u_mem (
    .tcb, .arst_n,
    .tcb_trn, .tcb_wen, .tcb_adr, .tcb_ben, .tcb_wdt,
    .tcb_vld_d, .tcb_wen_d, .tcb_err_d, .tcb_rdt
  );

  tcb_axil_rsp #(.DLY(DLY)) u_rsp (
    .tcb, .arst_n,
    .tcb_trn, .tcb_vld_d, .tcb_wen_d, .tcb_err_d, .tcb_rdt,
    .tcb_rdy,
    .bvalid, .bready, .bresp,
    .rvalid, .rready, .rdata, .rresp
  );

endmodule

`default_nettype wire

//--- tb_axil_tcb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axil_tcb_mem;

  localparam int unsigned SZ  = 1024;
  localparam int unsigned DLY = 2;
  // cycle limit for any one wait
  localparam int TMO = 200;

  logic           tcb;
  logic           arst_n;
  logic           awvalid;
  logic           awready;
  tcb_pkg::adr_t  awaddr;
  logic           wvalid;
  logic           wready;
  tcb_pkg::dat_t  wdata;
  tcb_pkg::ben_t  wstrb;
  logic           bvalid;
  logic           bready;
  tcb_pkg::resp_t bresp;
  logic           arvalid;
  logic           arready;
  tcb_pkg::adr_t  araddr;
  logic           rvalid;
  logic           rready;
  tcb_pkg::dat_t  rdata;
  tcb_pkg::resp_t rresp;

  // scoreboard copy of the byte array
  logic [7:0]  sb [0:SZ-1];
  logic [31:0] rng;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          err_mark = 0;
  string       cur_test = "none";

  axil_tcb_mem #(.SZ(SZ), .DLY(DLY)) DUT (
    .tcb, .arst_n,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp
  );

  initial begin
    tcb = 1'b0;
    forever #10 tcb = ~tcb;
  end

  //////////////////////////////
  // channel stability
  //////////////////////////////

  // B payload held until bready
  a_b_hold: assert property (@(posedge tcb) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $display("bvalid dropped or bresp changed before bready");
      errors++;
    end

  // R payload held until rready
  a_r_hold: assert property (@(posedge tcb) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $display("rvalid dropped or rdata/rresp changed before rready");
      errors++;
    end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // mixes every address bit into the word
  function automatic tcb_pkg::dat_t fill_pattern(input tcb_pkg::adr_t a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  // little endian word from the scoreboard
  function automatic tcb_pkg::dat_t expected_word(input tcb_pkg::adr_t a);
    tcb_pkg::dat_t w;
    for (int b = 0; b < tcb_pkg::BEW; b++) w[8*b +: 8] = sb[a + b];
    return w;
  endfunction

  // strobed lanes only, out of range leaves memory alone
  task automatic merge_write(input tcb_pkg::adr_t a, input tcb_pkg::dat_t d,
                             input tcb_pkg::ben_t s);
    if (a < SZ) begin
      for (int b = 0; b < tcb_pkg::BEW; b++) begin
        if (s[b]) sb[a + b] = d[8*b +: 8];
      end
    end
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("%s: timed out waiting for %s", cur_test, what);
    errors++;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic finish_test();
    tests++;
    $display("test %-14s %s", cur_test, (errors == err_mark) ? "ok" : "FAILED");
  endtask

  //////////////////////////////
  // AXI drivers
  //////////////////////////////

  // all drivers run 2 ns after a rising edge
  task automatic send_write(input tcb_pkg::adr_t a, input tcb_pkg::dat_t d,
                            input tcb_pkg::ben_t s);
    logic aw_hs;
    logic w_hs;
    int   n;
    awvalid = 1'b1;
    awaddr  = a;
    wvalid  = 1'b1;
    wdata   = d;
    wstrb   = s;
    n = 0;
    // each half drops on its own handshake
    while ((awvalid || wvalid) && n < TMO) begin
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(posedge tcb);
      #2;
      if (aw_hs) awvalid = 1'b0;
      if (w_hs) wvalid = 1'b0;
      n++;
    end
    if (awvalid || wvalid) begin
      timed_out("awready/wready");
      awvalid = 1'b0;
      wvalid  = 1'b0;
    end
  endtask

  // latency counts edges from the last handshake
  task automatic await_bresp(output tcb_pkg::resp_t r, output int lat);
    lat = 0;
    while (!bvalid && lat < TMO) begin
      @(posedge tcb);
      #2;
      lat++;
    end
    if (bvalid) begin
      r = bresp;
      @(posedge tcb);
      #2;
    end else begin
      r = 'x;
      timed_out("bvalid");
    end
  endtask

  task automatic send_read(input tcb_pkg::adr_t a);
    int n;
    arvalid = 1'b1;
    araddr  = a;
    n = 0;
    while (!arready && n < TMO) begin
      @(posedge tcb);
      #2;
      n++;
    end
    if (arready) begin
      @(posedge tcb);
      #2;
    end else begin
      timed_out("arready");
    end
    arvalid = 1'b0;
  endtask

  // rready must already be high
  task automatic await_rdata(output tcb_pkg::dat_t d, output tcb_pkg::resp_t r,
                             output int lat);
    lat = 0;
    while (!rvalid && lat < TMO) begin
      @(posedge tcb);
      #2;
      lat++;
    end
    if (rvalid) begin
      d = rdata;
      r = rresp;
      @(posedge tcb);
      #2;
    end else begin
      d = 'x;
      r = 'x;
      timed_out("rvalid");
    end
  endtask

  // out of range gives a slave error
  task automatic write_word(input tcb_pkg::adr_t a, input tcb_pkg::dat_t d,
                            input tcb_pkg::ben_t s, output int lat);
    tcb_pkg::resp_t r;
    send_write(a, d, s);
    await_bresp(r, lat);
    compare("bresp", 32'((a < SZ) ? tcb_pkg::RESP_OKAY : tcb_pkg::RESP_SLVERR), 32'(r));
    merge_write(a, d, s);
  endtask

  // out of range reads return zero
  task automatic read_word(input tcb_pkg::adr_t a, output int lat);
    tcb_pkg::resp_t r;
    tcb_pkg::dat_t  d;
    send_read(a);
    await_rdata(d, r, lat);
    compare("rresp", 32'((a < SZ) ? tcb_pkg::RESP_OKAY : tcb_pkg::RESP_SLVERR), 32'(r));
    compare("rdata", (a < SZ) ? expected_word(a) : 32'h0, d);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    tcb_pkg::adr_t  a;
    tcb_pkg::adr_t  wa;
    tcb_pkg::adr_t  ra;
    tcb_pkg::dat_t  wd;
    tcb_pkg::ben_t  ws;
    tcb_pkg::dat_t  d;
    tcb_pkg::resp_t r;
    tcb_pkg::adr_t  bp_q [$];
    int             lat;
    int             lat_w;
    int             lat_r;
    int             n;
    int             n_acc;
    logic           stalled;
    arst_n  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b1;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b1;
    rng     = 32'hebb5_ff18;

    start_test("reset");
    repeat (3) @(posedge tcb);
    #2;
    compare("bvalid in reset", 32'h0, 32'(bvalid));
    compare("rvalid in reset", 32'h0, 32'(rvalid));
    arst_n = 1'b1;
    finish_test();

    // known contents everywhere before any read
    start_test("fill");
    for (int i = 0; i < SZ; i += 4) begin
      write_word(i, fill_pattern(i), 4'hf, lat);
    end
    finish_test();

    start_test("word_rw");
    rng = xorshift(rng);
    write_word(32'h40, rng, 4'hf, lat);
    read_word(32'h40, lat);
    finish_test();

    start_test("strobes");
    write_word(32'h80, 32'h1122_3344, 4'hf, lat);
    write_word(32'h80, 32'haabb_ccdd, 4'b0100, lat);
    read_word(32'h80, lat);
    write_word(32'h80, 32'h5566_7788, 4'b0011, lat);
    read_word(32'h80, lat);
    write_word(32'h80, 32'h99ee_ff00, 4'b1000, lat);
    read_word(32'h80, lat);
    finish_test();

    // aliased word below SZ must stay as it was
    start_test("range_error");
    write_word(SZ + 32'h10, 32'hdead_beef, 4'hf, lat);
    read_word(SZ + 32'h10, lat);
    read_word(32'h10, lat);
    finish_test();

    start_test("backpressure");
    rready  = 1'b0;
    n_acc   = 0;
    stalled = 1'b0;
    while (!stalled && n_acc < 8) begin
      n = 0;
      while (!arready && n < DLY + 4) begin
        @(posedge tcb);
        #2;
        n++;
      end
      if (arready) begin
        rng = xorshift(rng);
        a = (rng % SZ) & ~32'd3;
        bp_q.push_back(a);
        send_read(a);
        n_acc++;
      end else begin
        stalled = 1'b1;
      end
    end
    compare("arready fell", 32'h1, 32'(stalled));
    compare("reads before stall", 32'h1, 32'(n_acc <= DLY + 4));
    // responses drain in issue order
    rready = 1'b1;
    while (bp_q.size() > 0) begin
      a = bp_q.pop_front();
      await_rdata(d, r, lat);
      compare("rresp", 32'(tcb_pkg::RESP_OKAY), 32'(r));
      compare("rdata", expected_word(a), d);
    end
    // write response held back by bready
    bready = 1'b0;
    rng = xorshift(rng);
    wa  = (rng % SZ) & ~32'd3;
    rng = xorshift(rng);
    wd  = rng;
    send_write(wa, wd, 4'hf);
    n = 0;
    while (!bvalid && n < TMO) begin
      @(posedge tcb);
      #2;
      n++;
    end
    if (!bvalid) begin
      timed_out("bvalid");
    end
    repeat (3) @(posedge tcb);
    #2;
    bready = 1'b1;
    await_bresp(r, lat);
    compare("bresp", 32'(tcb_pkg::RESP_OKAY), 32'(r));
    merge_write(wa, wd, 4'hf);
    finish_test();

    start_test("latency");
    write_word(32'h100, 32'h0bad_cafe, 4'hf, lat);
    compare("write latency", DLY + 2, lat);
    read_word(32'h100, lat);
    compare("read latency", DLY + 2, lat);
    finish_test();

    // read and write raised together, so the grant alternates
    start_test("random");
    for (int i = 0; i < 100; i++) begin
      rng = xorshift(rng);
      wa  = (rng % SZ) & ~32'd3;
      rng = xorshift(rng);
      ra  = (rng % SZ) & ~32'd3;
      if (ra == wa) ra = ra ^ 32'd4;
      rng = xorshift(rng);
      wd  = rng;
      rng = xorshift(rng);
      ws  = rng[3:0];
      fork
        write_word(wa, wd, ws, lat_w);
        read_word(ra, lat_r);
      join
    end
    finish_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
tcb_pkg.sv
axil_tcb_req.sv
tcb_mem.sv
tcb_axil_rsp.sv
axil_tcb_mem.sv
tb_axil_tcb_mem.sv

//--- Makefile
TOP := tb_axil_tcb_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
